//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb
FILELIST = tb.f
OBJDIR   = obj_dir

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# exit status of the simulation is the result
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- design/alu_if.sv
`default_nettype none

interface alu_if;
    logic                      start;   // one-cycle pulse, only while busy low
    logic [core_pkg::OP_W-1:0] op;      // alu_op_t or shift_op_t
    core_pkg::word_t           a;       // held by master while busy
    core_pkg::word_t           b;
    core_pkg::word_t           result;  // stable until next start
    logic                      busy;    // rises after start, falls with final result
    logic                      lt;      // compare flags
    logic                      eq;

    modport master (output start, op, a, b, input result, busy, lt, eq);
    modport unit (input start, op, a, b, output result, busy, lt, eq);
endinterface

`default_nettype wire

//--- design/control.sv
`default_nettype none

module control (
    input wire logic            clk,
    input wire logic            rst_n,
    alu_if.master               alu,
    alu_if.master               shf,
    output logic [4:0]          rs1_idx,
    output logic [4:0]          rs2_idx,
    output logic [4:0]          rd_idx,
    output logic                rd_we,
    output core_pkg::word_t     rd_data,
    input wire core_pkg::word_t rs1_data,
    input wire core_pkg::word_t rs2_data,
    output core_pkg::word_t     mem_addr,
    output core_pkg::word_t     mem_wdata,
    output logic                mem_re,
    output logic                mem_we,
    input wire core_pkg::word_t mem_rdata
);
    core_pkg::state_t    state;
    core_pkg::word_t     pc;
    riscv_pkg::instr_t   instr;
    logic                phase;     // set while the branch target sum runs
    riscv_pkg::opcode_t  opc;
    logic [2:0]          f3;
    core_pkg::word_t     pc_plus4;
    core_pkg::word_t     op_a;
    core_pkg::word_t     op_b;
    core_pkg::alu_op_t   alu_op;
    core_pkg::shift_op_t shf_op;
    logic                is_arith;  // OP or OP-IMM
    logic                is_shift;
    logic                is_slt;
    logic                is_jump;
    logic                illegal;
    logic                taken;
    logic                alu_done;

    assign opc      = instr.opcode;
    assign f3       = instr.funct3;
    assign pc_plus4 = pc + core_pkg::word_t'(4);
    assign is_arith = (opc == riscv_pkg::OPC_OP) || (opc == riscv_pkg::OPC_OP_IMM);
    assign is_shift = is_arith && (f3 == riscv_pkg::F3_SLL || f3 == riscv_pkg::F3_SRL);
    assign is_slt   = is_arith && (f3 == riscv_pkg::F3_SLT || f3 == riscv_pkg::F3_SLTU);
    assign is_jump  = (opc == riscv_pkg::OPC_JAL) || (opc == riscv_pkg::OPC_JALR);
    assign alu_done = (state == core_pkg::ST_ALU_RUN) && !alu.busy;

    always_comb begin
        case (opc)
            riscv_pkg::OPC_LOAD, riscv_pkg::OPC_STORE: illegal = (f3 != riscv_pkg::F3_W);
            riscv_pkg::OPC_BRANCH: illegal = (f3[2:1] == 2'b01);  // no branch on 010, 011
            riscv_pkg::OPC_LUI, riscv_pkg::OPC_AUIPC, riscv_pkg::OPC_JAL,
            riscv_pkg::OPC_JALR, riscv_pkg::OPC_OP, riscv_pkg::OPC_OP_IMM: illegal = 1'b0;
            default: illegal = 1'b1;
        endcase
    end

    // operand and op select for the one shared adder
    always_comb begin
        op_a   = rs1_data;
        op_b   = riscv_pkg::imm_i(instr);  // op-imm, jalr, lw
        alu_op = core_pkg::ALU_ADD;
        case (opc)
            riscv_pkg::OPC_LUI: begin
                op_a = '0;
                op_b = riscv_pkg::imm_u(instr);
            end
            riscv_pkg::OPC_AUIPC: begin
                op_a = pc;
                op_b = riscv_pkg::imm_u(instr);
            end
            riscv_pkg::OPC_JAL: begin
                op_a = pc;
                op_b = riscv_pkg::imm_j(instr);
            end
            riscv_pkg::OPC_STORE: op_b = riscv_pkg::imm_s(instr);
            riscv_pkg::OPC_BRANCH: begin
                if (phase || alu_done) begin  // pc + imm pass
                    op_a = pc;
                    op_b = riscv_pkg::imm_b(instr);
                end else begin
                    op_b = rs2_data;
                    if (f3 == riscv_pkg::F3_BLTU || f3 == riscv_pkg::F3_BGEU)
                        alu_op = core_pkg::ALU_CMP_U;
                    else
                        alu_op = core_pkg::ALU_CMP_S;
                end
            end
            riscv_pkg::OPC_OP, riscv_pkg::OPC_OP_IMM: begin
                if (opc == riscv_pkg::OPC_OP)
                    op_b = rs2_data;
                case (f3)
                    riscv_pkg::F3_ADD:
                        if (opc == riscv_pkg::OPC_OP && instr.funct7[5])
                            alu_op = core_pkg::ALU_SUB;
                    riscv_pkg::F3_SLT:  alu_op = core_pkg::ALU_CMP_S;
                    riscv_pkg::F3_SLTU: alu_op = core_pkg::ALU_CMP_U;
                    riscv_pkg::F3_XOR:  alu_op = core_pkg::ALU_XOR;
                    riscv_pkg::F3_OR:   alu_op = core_pkg::ALU_OR;
                    riscv_pkg::F3_AND:  alu_op = core_pkg::ALU_AND;
                    default: ;  // shifts go to shift_loop
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        if (f3 == riscv_pkg::F3_SLL)
            shf_op = core_pkg::SHF_SLL;
        else if (instr.funct7[5])
            shf_op = core_pkg::SHF_SRA;
        else
            shf_op = core_pkg::SHF_SRL;
    end

    always_comb begin
        case (f3)
            riscv_pkg::F3_BEQ:                    taken = alu.eq;
            riscv_pkg::F3_BNE:                    taken = !alu.eq;
            riscv_pkg::F3_BLT, riscv_pkg::F3_BLTU: taken = alu.lt;
            riscv_pkg::F3_BGE, riscv_pkg::F3_BGEU: taken = !alu.lt;
            default:                              taken = 1'b0;
        endcase
    end

    assign alu.a  = op_a;
    assign alu.b  = op_b;
    assign alu.op = alu_op;
    assign shf.a  = rs1_data;
    assign shf.b  = core_pkg::word_t'(op_b[4:0]);  // shamt only
    assign shf.op = shf_op;

    // second pass on a taken branch for pc + imm
    assign alu.start = (state == core_pkg::ST_DECODE && !illegal && !is_shift)
                     || (alu_done && opc == riscv_pkg::OPC_BRANCH && !phase && taken);
    assign shf.start = (state == core_pkg::ST_DECODE) && !illegal && is_shift;

    assign mem_re    = (state == core_pkg::ST_INSTR_FETCH) || (state == core_pkg::ST_MEM_READ);
    assign mem_we    = (state == core_pkg::ST_MEM_WRITE);
    assign mem_addr  = (state == core_pkg::ST_INSTR_FETCH) ? pc : alu.result;
    assign mem_wdata = rs2_data;

    assign rs1_idx = instr.rs1;
    assign rs2_idx = instr.rs2;
    assign rd_idx  = instr.rd;
    assign rd_we   = (state == core_pkg::ST_WRITE_BACK) || (state == core_pkg::ST_MEM_WAIT);

    always_comb begin
        if (state == core_pkg::ST_MEM_WAIT)
            rd_data = mem_rdata;  // lw data
        else if (is_jump)
            rd_data = pc_plus4;   // link
        else if (is_shift)
            rd_data = shf.result;
        else if (is_slt)
            rd_data = core_pkg::word_t'(alu.lt);
        else
            rd_data = alu.result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= core_pkg::ST_RESET;
            pc    <= core_pkg::START_ADDR;
            phase <= 1'b0;
        end else begin
            case (state)
                core_pkg::ST_RESET:       state <= core_pkg::ST_INSTR_FETCH;
                core_pkg::ST_INSTR_FETCH: state <= core_pkg::ST_INSTR_WAIT;
                core_pkg::ST_INSTR_WAIT:  state <= core_pkg::ST_DECODE;
                core_pkg::ST_DECODE: begin
                    if (illegal)
                        state <= core_pkg::ST_ERROR;
                    else if (is_shift)
                        state <= core_pkg::ST_SHIFT_RUN;
                    else
                        state <= core_pkg::ST_ALU_RUN;
                end
                core_pkg::ST_ALU_RUN: begin
                    if (!alu.busy) begin
                        case (opc)
                            riscv_pkg::OPC_LOAD:  state <= core_pkg::ST_MEM_READ;
                            riscv_pkg::OPC_STORE: state <= core_pkg::ST_MEM_WRITE;
                            riscv_pkg::OPC_BRANCH: begin
                                if (!phase && taken) begin
                                    phase <= 1'b1;  // target sum running
                                end else begin
                                    pc    <= phase ? alu.result : pc_plus4;
                                    phase <= 1'b0;
                                    state <= core_pkg::ST_INSTR_FETCH;
                                end
                            end
                            default: state <= core_pkg::ST_WRITE_BACK;
                        endcase
                    end
                end
                core_pkg::ST_SHIFT_RUN: begin
                    if (!shf.busy)
                        state <= core_pkg::ST_WRITE_BACK;
                end
                core_pkg::ST_MEM_READ: state <= core_pkg::ST_MEM_WAIT;
                core_pkg::ST_MEM_WAIT, core_pkg::ST_MEM_WRITE: begin
                    pc    <= pc_plus4;
                    state <= core_pkg::ST_INSTR_FETCH;
                end
                core_pkg::ST_WRITE_BACK: begin
                    pc    <= is_jump ? {alu.result[core_pkg::XLEN-1:1], 1'b0} : pc_plus4;
                    state <= core_pkg::ST_INSTR_FETCH;
                end
                default: state <= core_pkg::ST_ERROR;  // parked
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::ST_INSTR_WAIT)
            instr <= riscv_pkg::instr_t'(mem_rdata);
    end

    a_bus_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_re && mem_we));
    a_alu_start: assert property (@(posedge clk) disable iff (!rst_n) alu.start |-> !alu.busy);
    a_shf_start: assert property (@(posedge clk) disable iff (!rst_n) shf.start |-> !shf.busy);
    a_err_hold: assert property (@(posedge clk) disable iff (!rst_n)
        state == core_pkg::ST_ERROR |=> state == core_pkg::ST_ERROR);

endmodule

`default_nettype wire

//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN    = 32;           // data word width
    localparam int NIBBLES = XLEN / 4;     // steps in one nibble loop
    localparam int NIB_W   = $clog2(NIBBLES);
    localparam int OP_W    = 3;            // op field width on alu_if

    localparam logic [NIB_W-1:0] NIB_LAST = NIB_W'(NIBBLES - 1);

    typedef logic [XLEN-1:0] word_t;

    localparam word_t START_ADDR = word_t'(24'hff0004);  // pc after reset

    typedef enum logic [3:0] {
        ST_RESET,
        ST_INSTR_FETCH,    // mem_re at pc
        ST_INSTR_WAIT,     // instr word on mem_rdata
        ST_DECODE,
        ST_ALU_RUN,
        ST_SHIFT_RUN,
        ST_MEM_READ,
        ST_MEM_WAIT,
        ST_MEM_WRITE,
        ST_WRITE_BACK,
        ST_ERROR           // unknown opcode, left only by reset
    } state_t;

    typedef enum logic [OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_CMP_S,         // lt and eq, signed
        ALU_CMP_U          // lt and eq, unsigned
    } alu_op_t;

    typedef enum logic [OP_W-1:0] {
        SHF_SLL,
        SHF_SRL,
        SHF_SRA
    } shift_op_t;

endpackage

`default_nettype wire

//--- design/nibble_alu.sv
`default_nettype none

module nibble_alu (
    input wire logic clk,
    input wire logic rst_n,
    alu_if.unit      port
);
    core_pkg::word_t            opa;      // operands shifted down a nibble per step
    core_pkg::word_t            opb;
    core_pkg::word_t            acc;      // result filled from the top
    core_pkg::alu_op_t          op_q;
    logic [core_pkg::NIB_W-1:0] idx;      // current nibble
    logic                       busy;
    logic                       carry;
    logic                       nonzero;  // any result nibble set so far
    logic                       lt_q;
    logic                       eq_q;
    logic                       last;
    logic [3:0]                 b_nib;
    logic [4:0]                 sum;
    logic [3:0]                 nib;
    logic                       lt_next;

    assign last  = (idx == core_pkg::NIB_LAST);
    assign b_nib = (op_q == core_pkg::ALU_ADD) ? opb[3:0] : ~opb[3:0];  // sub, cmp invert b
    assign sum   = {1'b0, opa[3:0]} + {1'b0, b_nib} + {4'b0, carry};

    always_comb begin
        case (op_q)
            core_pkg::ALU_AND: nib = opa[3:0] & opb[3:0];
            core_pkg::ALU_OR:  nib = opa[3:0] | opb[3:0];
            core_pkg::ALU_XOR: nib = opa[3:0] ^ opb[3:0];
            default:           nib = sum[3:0];  // add, sub, compares
        endcase
    end

    // negative a wins when signs differ, else lt is no carry out
    assign lt_next = (op_q == core_pkg::ALU_CMP_S && opa[3] != opb[3]) ? opa[3] : !sum[4];

    assign port.result = acc;
    assign port.busy   = busy;
    assign port.lt     = lt_q;
    assign port.eq     = eq_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            idx     <= '0;
            carry   <= 1'b0;
            nonzero <= 1'b0;
        end else if (port.start) begin
            busy    <= 1'b1;
            idx     <= '0;
            carry   <= (core_pkg::alu_op_t'(port.op) != core_pkg::ALU_ADD);  // +1 for two's compl
            nonzero <= 1'b0;
        end else if (busy) begin
            carry   <= sum[4];
            nonzero <= nonzero | (|nib);
            if (last)
                busy <= 1'b0;  // result final this cycle
            else
                idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.start) begin
            opa  <= port.a;
            opb  <= port.b;
            op_q <= core_pkg::alu_op_t'(port.op);
        end else if (busy) begin
            opa <= opa >> 4;
            opb <= opb >> 4;
            acc <= {nib, acc[core_pkg::XLEN-1:4]};
            if (last) begin
                lt_q <= lt_next;
                eq_q <= !(nonzero || (|nib));
            end
        end
    end

    // index stops at the last nibble, no wrap
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        busy && last |=> idx == core_pkg::NIB_LAST);

    // busy for exactly one nibble loop
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        port.start |=> busy [*core_pkg::NIBBLES] ##1 !busy);

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

module reg_file (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic [4:0]      rs1_idx,
    input wire logic [4:0]      rs2_idx,
    input wire logic [4:0]      rd_idx,
    input wire logic            rd_we,
    input wire core_pkg::word_t rd_data,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);
    core_pkg::word_t regs [32];

    assign rs1_data = regs[rs1_idx];  // async read
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_idx != 5'd0) begin  // x0 stays zero
            regs[rd_idx] <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- design/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // OP and OP-IMM, srl and sra share a code
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_W    = 3'b010;  // only lw and sw width

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } instr_t;

    function automatic core_pkg::word_t imm_i(input instr_t ins);
        return {{20{ins.funct7[6]}}, ins.funct7, ins.rs2};
    endfunction

    function automatic core_pkg::word_t imm_s(input instr_t ins);
        return {{20{ins.funct7[6]}}, ins.funct7, ins.rd};
    endfunction

    function automatic core_pkg::word_t imm_b(input instr_t ins);
        return {{19{ins.funct7[6]}}, ins.funct7[6], ins.rd[0], ins.funct7[5:0],
                ins.rd[4:1], 1'b0};
    endfunction

    function automatic core_pkg::word_t imm_u(input instr_t ins);
        return {ins.funct7, ins.rs2, ins.rs1, ins.funct3, 12'b0};
    endfunction

    function automatic core_pkg::word_t imm_j(input instr_t ins);
        return {{11{ins.funct7[6]}}, ins.funct7[6], ins.rs1, ins.funct3, ins.rs2[0],
                ins.funct7[5:0], ins.rs2[4:1], 1'b0};
    endfunction

endpackage

`default_nettype wire

//--- design/rv_core.sv
`default_nettype none

module rv_core (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire core_pkg::word_t mem_rdata,
    output core_pkg::word_t     mem_addr,
    output core_pkg::word_t     mem_wdata,
    output logic                mem_re,
    output logic                mem_we
);
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [4:0]      rd_idx;
    logic            rd_we;
    core_pkg::word_t rd_data;
    core_pkg::word_t rs1_data;
    core_pkg::word_t rs2_data;

    alu_if alu_bus ();  // control to nibble_alu
    alu_if shf_bus ();  // control to shift_loop

    control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu       (alu_bus.master),
        .shf       (shf_bus.master),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rd_idx    (rd_idx),
        .rd_we     (rd_we),
        .rd_data   (rd_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    nibble_alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (alu_bus.unit)
    );

    shift_loop u_shift (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (shf_bus.unit)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rd_idx   (rd_idx),
        .rd_we    (rd_we),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

//--- design/shift_loop.sv
`default_nettype none

module shift_loop (
    input wire logic clk,
    input wire logic rst_n,
    alu_if.unit      port
);
    core_pkg::word_t     val;   // shifting word
    core_pkg::shift_op_t op_q;
    logic [4:0]          cnt;   // positions still to go
    logic                busy;
    logic                fill;  // bit entering from the top

    assign fill = (op_q == core_pkg::SHF_SRA) && val[core_pkg::XLEN-1];

    assign port.result = val;
    assign port.busy   = busy;
    assign port.lt     = 1'b0;  // no compare here
    assign port.eq     = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (port.start) begin
            busy <= 1'b1;
            cnt  <= port.b[4:0];  // shamt in low bits of b
        end else if (busy) begin
            if (cnt == '0)
                busy <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.start) begin
            val  <= port.a;
            op_q <= core_pkg::shift_op_t'(port.op);
        end else if (busy && cnt != '0) begin
            if (op_q == core_pkg::SHF_SLL)
                val <= {val[core_pkg::XLEN-2:0], 1'b0};
            else
                val <= {fill, val[core_pkg::XLEN-1:1]};  // srl zero, sra sign
        end
    end

    a_cnt_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy && !port.start |=> $stable(cnt));

endmodule

`default_nettype wire

//--- sim/core_trace.txt
# M addr data = memory preload, F addr = next expected fetch
# S addr data = next expected store, all values in hex
# data words, base 00ff1000 set by lui x1
M 00ff1000 cafebabe
M 00ff0ffc 00000035
# lui, lw, alu ops each followed by sw
M 00ff0004 00ff10b7
M 00ff0008 0000a103
M 00ff000c ffc0a183
M 00ff0010 ffd00213
M 00ff0014 004182b3
M 00ff0018 1050a023
M 00ff001c 404182b3
M 00ff0020 1050a223
M 00ff0024 004172b3
M 00ff0028 1050a423
M 00ff002c 0041e2b3
M 00ff0030 1050a623
M 00ff0034 003142b3
M 00ff0038 1050a823
M 00ff003c 003222b3
M 00ff0040 1050aa23
M 00ff0044 003232b3
M 00ff0048 1050ac23
M 00ff004c fff12293
M 00ff0050 1050ae23
M 00ff0054 03513293
M 00ff0058 1250a023
# shifts by 2 and by 0
M 00ff005c 00200313
M 00ff0060 006112b3
M 00ff0064 1250a223
M 00ff0068 006152b3
M 00ff006c 1250a423
M 00ff0070 406152b3
M 00ff0074 1250a623
M 00ff0078 000112b3
M 00ff007c 1250a823
M 00ff0080 40015293
M 00ff0084 1250aa23
M 00ff0088 00219293
M 00ff008c 1250ac23
M 00ff0090 0021d293
M 00ff0094 1250ae23
M 00ff0098 40225293
M 00ff009c 1450a023
# lui, auipc, sw with negative offset, x0
M 00ff00a0 123453b7
M 00ff00a4 1470a223
M 00ff00a8 00001397
M 00ff00ac 1470a423
M 00ff00b0 fe30ac23
M 00ff00b4 00500013
M 00ff00b8 1400a623
# branches, taken ones skip a zero word
M 00ff00bc 00318463
M 00ff00c4 00418463
M 00ff00c8 00419463
M 00ff00d0 00319463
M 00ff00d4 00324463
M 00ff00dc 0041c463
M 00ff00e0 0041d463
M 00ff00e8 00325463
M 00ff00ec 0041e463
M 00ff00f4 00326463
M 00ff00f8 00327463
M 00ff0100 0041f463
# jal, auipc, jalr, link stores
M 00ff0104 00c0046f
M 00ff0110 1480a823
M 00ff0114 00000497
M 00ff0118 01048567
M 00ff0124 14a0aa23
M 00ff0128 0000006f
F 00ff0004
F 00ff0008
F 00ff000c
F 00ff0010
F 00ff0014
F 00ff0018
F 00ff001c
F 00ff0020
F 00ff0024
F 00ff0028
F 00ff002c
F 00ff0030
F 00ff0034
F 00ff0038
F 00ff003c
F 00ff0040
F 00ff0044
F 00ff0048
F 00ff004c
F 00ff0050
F 00ff0054
F 00ff0058
F 00ff005c
F 00ff0060
F 00ff0064
F 00ff0068
F 00ff006c
F 00ff0070
F 00ff0074
F 00ff0078
F 00ff007c
F 00ff0080
F 00ff0084
F 00ff0088
F 00ff008c
F 00ff0090
F 00ff0094
F 00ff0098
F 00ff009c
F 00ff00a0
F 00ff00a4
F 00ff00a8
F 00ff00ac
F 00ff00b0
F 00ff00b4
F 00ff00b8
F 00ff00bc
F 00ff00c4
F 00ff00c8
F 00ff00d0
F 00ff00d4
F 00ff00dc
F 00ff00e0
F 00ff00e8
F 00ff00ec
F 00ff00f4
F 00ff00f8
F 00ff0100
F 00ff0104
F 00ff0110
F 00ff0114
F 00ff0118
F 00ff0124
F 00ff0128
S 00ff1100 00000032
S 00ff1104 00000038
S 00ff1108 cafebabc
S 00ff110c fffffffd
S 00ff1110 cafeba8b
S 00ff1114 00000001
S 00ff1118 00000000
S 00ff111c 00000001
S 00ff1120 00000000
S 00ff1124 2bfaeaf8
S 00ff1128 32bfaeaf
S 00ff112c f2bfaeaf
S 00ff1130 cafebabe
S 00ff1134 cafebabe
S 00ff1138 000000d4
S 00ff113c 0000000d
S 00ff1140 ffffffff
S 00ff1144 12345000
S 00ff1148 00ff10a8
S 00ff0ff8 00000035
S 00ff114c 00000000
S 00ff1150 00ff0108
S 00ff1154 00ff011c

//--- sim/tb.sv
`default_nettype none

module tb;
    logic            clk;
    logic            rst_n;
    core_pkg::word_t mem_rdata;
    core_pkg::word_t mem_addr;
    core_pkg::word_t mem_wdata;
    logic            mem_re;
    logic            mem_we;

    core_pkg::word_t mem_model [core_pkg::word_t];  // sparse word memory
    core_pkg::word_t fetch_q [$];                   // expected fetch addresses
    core_pkg::word_t store_addr_q [$];              // expected stores, in order
    core_pkg::word_t store_data_q [$];
    int              line_count = 0;                // trace entries, sizes the watchdog
    logic            load_pending;                  // next read is lw data

    rv_core dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_re    (mem_re),
        .mem_we    (mem_we)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // period 20
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic core_pkg::word_t read_word(input core_pkg::word_t addr);
        return mem_model.exists(addr) ? mem_model[addr] : '0;  // unwritten reads as zero
    endfunction

    // M addr data, F addr, S addr data; # starts a comment line
    task automatic load_trace();
        int              fd;
        int              n;
        string           kind;
        string           rest;
        core_pkg::word_t a;
        core_pkg::word_t d;
        fd = $fopen("sim/core_trace.txt", "r");
        if (fd == 0)
            stop_run("could not open the trace file sim/core_trace.txt");
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1)
                break;  // end of file
            if (kind == "#") begin
                n = $fgets(rest, fd);  // drop rest of comment
            end else if (kind == "M") begin
                n = $fscanf(fd, "%h %h", a, d);
                mem_model[a] = d;
                line_count++;
            end else if (kind == "F") begin
                n = $fscanf(fd, "%h", a);
                fetch_q.push_back(a);
                line_count++;
            end else if (kind == "S") begin
                n = $fscanf(fd, "%h %h", a, d);
                store_addr_q.push_back(a);
                store_data_q.push_back(d);
                line_count++;
            end else begin
                stop_run({"unknown line kind in the trace file: ", kind});
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_fetch(input core_pkg::word_t got);
        if (fetch_q.size() == 0)
            stop_run("the core fetched after the last expected fetch");
        if (got !== fetch_q[0]) begin
            $display("Fail mem_addr (fetch): got %h expected %h", got, fetch_q[0]);
            stop_run("fetch address mismatch");
        end
        void'(fetch_q.pop_front());
    endtask

    task automatic compare_store(input core_pkg::word_t addr, input core_pkg::word_t data);
        if (store_addr_q.size() == 0)
            stop_run("the core wrote memory with no store left in the trace");
        if (addr !== store_addr_q[0]) begin
            $display("Fail mem_addr (store): got %h expected %h", addr, store_addr_q[0]);
            stop_run("store address mismatch");
        end
        if (data !== store_data_q[0]) begin
            $display("Fail mem_wdata: got %h expected %h", data, store_data_q[0]);
            stop_run("store data mismatch");
        end
        void'(store_addr_q.pop_front());
        void'(store_data_q.pop_front());
    endtask

    // limit scales with the trace length
    initial begin
        wait (line_count > 0);
        repeat (200 * line_count) @(posedge clk);
        stop_run("watchdog expired before the trace was consumed");
    end

    initial begin
        core_pkg::word_t a;
        core_pkg::word_t d;
        logic            re;
        logic            we;
        core_pkg::word_t word;
        rst_n        = 1'b0;
        mem_rdata    = '0;
        load_pending = 1'b0;
        load_trace();
        repeat (8) begin
            @(posedge clk);
            if (mem_re || mem_we)
                stop_run("a bus strobe was high during reset");
        end
        #2 rst_n = 1'b1;
        forever begin
            @(posedge clk);
            re = mem_re;  // sampled before any state update
            we = mem_we;
            a  = mem_addr;
            d  = mem_wdata;
            if (re && we)
                stop_run("read and write strobes were high together");
            if (we) begin
                compare_store(a, d);
                mem_model[a] = d;
            end
            if (re) begin
                if (load_pending) begin
                    load_pending = 1'b0;  // lw data read, address checked by stored results
                end else begin
                    compare_fetch(a);
                    word         = read_word(a);
                    load_pending = (word[6:0] == 7'b0000011);  // LOAD opcode
                end
            end
            if (fetch_q.size() == 0 && store_addr_q.size() == 0) begin
                $display("TEST OK");
                $finish;
            end
            #2;
            if (re)
                mem_rdata = read_word(a);  // one-cycle read latency
        end
    end

endmodule

`default_nettype wire

//--- tb.f
design/core_pkg.sv
design/riscv_pkg.sv
design/alu_if.sv
design/nibble_alu.sv
design/shift_loop.sv
design/reg_file.sv
design/control.sv
design/rv_core.sv
sim/tb.sv
